/* rtl/bounce_pkg.sv */
// Shared types and game constants for the bee dodging game
`default_nettype none

package bounce_pkg;

    typedef logic [7:0] x_t;
    typedef logic [6:0] y_t;
    typedef logic [2:0] colour_t;

    typedef struct packed {
        logic x_left;
        logic y_up;
    } heading_t;

    typedef enum logic [1:0] {
        PLOT_IDLE,
        PLOT_ERASE,
        PLOT_DRAW
    } plot_state_t;

    // Playfield borders inside the 160x120 screen
    localparam x_t X_MIN = 8'd4;
    localparam x_t X_MAX = 8'd152;
    localparam y_t Y_MIN = 7'd24;
    localparam y_t Y_MAX = 7'd112;
    localparam int FIELD_W = 160;
    localparam int FIELD_H = 120;
    localparam int HIT_RADIUS = 3;

    localparam colour_t COLOUR_BG = 3'd0;
    localparam colour_t COLOUR_BEE = 3'd6;
    localparam colour_t COLOUR_BEE_OFF = 3'd7;
    localparam colour_t COLOUR_PLAYER_LOW = 3'd4;
    localparam colour_t COLOUR_PLAYER_MID = 3'd5;
    localparam colour_t COLOUR_PLAYER_HIGH = 3'd1;

    localparam x_t PLAYER_START_X = 8'd80;
    localparam y_t PLAYER_START_Y = 7'd60;
    localparam logic [1:0] LIVES_START = 2'd3;
    localparam logic [1:0] LIVES_AFTER_OVER = 2'd2;

    localparam int NUM_BEES = 4;
    // Player plus every bee on the pixel port
    localparam int NUM_SRCS = NUM_BEES + 1;
    localparam int SRC_W = $clog2(NUM_SRCS);

    // Tick periods in clocks
    localparam int FAST_MOVE_CYCLES = 8;
    localparam int SLOW_MOVE_CYCLES = 16;
    localparam int SCORE_CYCLES = 64;
    localparam int TICK_CNT_W = $clog2(SCORE_CYCLES);

endpackage

`default_nettype wire

/* rtl/plot_if.sv */
// Pixel request channel from a sprite to the pixel port arbiter
`timescale 1ns/1ps
`default_nettype none

interface plot_if;

    import bounce_pkg::*;

    logic valid;
    logic ready;
    x_t x;
    y_t y;
    colour_t colour;

    modport source (output valid, output x, output y, output colour, input ready);

    modport sink (input valid, input x, input y, input colour, output ready);

endinterface

`default_nettype wire

/* rtl/game_timer.sv */
// Move tick and score tick generators
`timescale 1ns/1ps
`default_nettype none

module game_timer
    (
    input logic CLOCK_50,
    input logic reset,
    input logic fast,
    output logic move_tick,
    output logic score_tick
    );

    import bounce_pkg::*;

    logic [TICK_CNT_W-1:0] move_cnt;
    logic [TICK_CNT_W-1:0] score_cnt;
    logic [TICK_CNT_W-1:0] move_reload;

    // Speed is sampled at every reload
    assign move_reload = fast ? TICK_CNT_W'(FAST_MOVE_CYCLES - 1)
                              : TICK_CNT_W'(SLOW_MOVE_CYCLES - 1);

    assign move_tick = (move_cnt == '0);
    assign score_tick = (score_cnt == '0);

    always_ff @(posedge CLOCK_50)
    begin
        if (reset)
        begin
            move_cnt <= move_reload;
            score_cnt <= TICK_CNT_W'(SCORE_CYCLES - 1);
        end
        else
        begin
            move_cnt <= move_tick ? move_reload : move_cnt - 1'b1;
            score_cnt <= score_tick ? TICK_CNT_W'(SCORE_CYCLES - 1) : score_cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/player_mover.sv */
// Player sprite position, key steering, respawn and erase/draw sequencing
`timescale 1ns/1ps
`default_nettype none

module player_mover
    (
    input logic CLOCK_50,
    input logic reset,
    input logic move_tick,
    input logic [3:0] keys,
    input logic [1:0] lives,
    input logic respawn,
    output logic respawn_done,
    output bounce_pkg::x_t player_x,
    output bounce_pkg::y_t player_y,
    plot_if.source plot
    );

    import bounce_pkg::*;

    plot_state_t state;
    colour_t colour_q;
    colour_t draw_colour;
    x_t next_x;
    y_t next_y;
    logic xfer;

    assign xfer = plot.valid && plot.ready;

    // Player turns redder as lives run out
    always_comb
    begin
        case (lives)
            2'd0: draw_colour = COLOUR_PLAYER_LOW;
            2'd1: draw_colour = COLOUR_PLAYER_MID;
            default: draw_colour = COLOUR_PLAYER_HIGH;
        endcase
    end

    // keys[3] up, keys[2] down, keys[1] left, keys[0] right
    // Opposite keys cancel each other
    always_comb
    begin
        if (respawn)
        begin
            next_x = PLAYER_START_X;
            next_y = PLAYER_START_Y;
        end
        else
        begin
            next_x = player_x + x_t'(keys[0]) - x_t'(keys[1]);
            next_y = player_y + y_t'(keys[2]) - y_t'(keys[3]);
        end
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (reset)
        begin
            state <= PLOT_IDLE;
            player_x <= PLAYER_START_X;
            player_y <= PLAYER_START_Y;
            respawn_done <= 1'b0;
        end
        else
        begin
            respawn_done <= 1'b0;
            case (state)
                PLOT_IDLE:
                    // A tick while busy is simply skipped
                    if (move_tick)
                        state <= PLOT_ERASE;
                PLOT_ERASE:
                    if (xfer)
                    begin
                        player_x <= next_x;
                        player_y <= next_y;
                        respawn_done <= respawn;
                        state <= PLOT_DRAW;
                    end
                PLOT_DRAW:
                    if (xfer)
                        state <= PLOT_IDLE;
                default:
                    state <= PLOT_IDLE;
            endcase
        end
    end

    // Colour held fixed while the draw waits for ready
    always_ff @(posedge CLOCK_50)
    begin
        if (state == PLOT_ERASE && xfer)
            colour_q <= draw_colour;
    end

    // Erase shows the old spot and draw the new one
    assign plot.valid = (state != PLOT_IDLE);
    assign plot.x = player_x;
    assign plot.y = player_y;
    assign plot.colour = (state == PLOT_DRAW) ? colour_q : COLOUR_BG;

endmodule

`default_nettype wire

/* rtl/bee_mover.sv */
// One bee bouncing diagonally off the field borders, with erase/draw sequencing
`timescale 1ns/1ps
`default_nettype none

module bee_mover
    #(
    parameter bounce_pkg::x_t START_X = 8'd30,
    parameter bounce_pkg::y_t START_Y = 7'd48,
    parameter bounce_pkg::heading_t START_HEADING = '0
    )
    (
    input logic CLOCK_50,
    input logic reset,
    input logic move_tick,
    input logic enable,
    output bounce_pkg::x_t bee_x,
    output bounce_pkg::y_t bee_y,
    plot_if.source plot
    );

    import bounce_pkg::*;

    plot_state_t state;
    heading_t heading;
    heading_t next_heading;
    colour_t colour_q;
    logic xfer;

    assign xfer = plot.valid && plot.ready;

    // Bounce off the borders before stepping
    always_comb
    begin
        next_heading = heading;
        if (bee_x >= X_MAX)
            next_heading.x_left = 1'b1;
        else if (bee_x <= X_MIN)
            next_heading.x_left = 1'b0;
        if (bee_y == Y_MAX)
            next_heading.y_up = 1'b1;
        else if (bee_y == Y_MIN)
            next_heading.y_up = 1'b0;
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (reset)
        begin
            state <= PLOT_IDLE;
            heading <= START_HEADING;
            bee_x <= START_X;
            bee_y <= START_Y;
        end
        else
        begin
            case (state)
                PLOT_IDLE:
                    if (move_tick)
                        state <= PLOT_ERASE;
                PLOT_ERASE:
                    if (xfer)
                    begin
                        heading <= next_heading;
                        bee_x <= next_heading.x_left ? bee_x - 1'b1 : bee_x + 1'b1;
                        bee_y <= next_heading.y_up ? bee_y - 1'b1 : bee_y + 1'b1;
                        state <= PLOT_DRAW;
                    end
                PLOT_DRAW:
                    if (xfer)
                        state <= PLOT_IDLE;
                default:
                    state <= PLOT_IDLE;
            endcase
        end
    end

    // Disabled bees still fly, drawn in white
    always_ff @(posedge CLOCK_50)
    begin
        if (state == PLOT_ERASE && xfer)
            colour_q <= enable ? COLOUR_BEE : COLOUR_BEE_OFF;
    end

    assign plot.valid = (state != PLOT_IDLE);
    assign plot.x = bee_x;
    assign plot.y = bee_y;
    assign plot.colour = (state == PLOT_DRAW) ? colour_q : COLOUR_BG;

endmodule

`default_nettype wire

/* rtl/collision_lives.sv */
// Wall and bee collision detection, lives count, respawn request and game over
`timescale 1ns/1ps
`default_nettype none

module collision_lives
    (
    input logic CLOCK_50,
    input logic reset,
    input logic move_tick,
    input bounce_pkg::x_t player_x,
    input bounce_pkg::y_t player_y,
    input bounce_pkg::x_t bee_x [bounce_pkg::NUM_BEES],
    input bounce_pkg::y_t bee_y [bounce_pkg::NUM_BEES],
    input logic [bounce_pkg::NUM_BEES-1:0] bee_enable,
    input logic respawn_done,
    output logic [1:0] lives,
    output logic respawn,
    output logic game_over
    );

    import bounce_pkg::*;

    x_t [NUM_BEES-1:0] dx;
    y_t [NUM_BEES-1:0] dy;
    logic [NUM_BEES-1:0] near;
    logic wall_hit;
    logic hit;

    assign wall_hit = (player_x >= X_MAX) || (player_x <= X_MIN)
                   || (player_y >= Y_MAX) || (player_y <= Y_MIN);

    // Box test around each enabled bee
    for (genvar i = 0; i < NUM_BEES; i++)
    begin : g_near
        assign dx[i] = (player_x >= bee_x[i]) ? player_x - bee_x[i] : bee_x[i] - player_x;
        assign dy[i] = (player_y >= bee_y[i]) ? player_y - bee_y[i] : bee_y[i] - player_y;
        assign near[i] = bee_enable[i] && (dx[i] <= x_t'(HIT_RADIUS))
                      && (dy[i] <= y_t'(HIT_RADIUS));
    end

    assign hit = wall_hit || (|near);

    always_ff @(posedge CLOCK_50)
    begin
        if (reset)
        begin
            lives <= LIVES_START;
            respawn <= 1'b0;
            game_over <= 1'b0;
        end
        else
        begin
            game_over <= 1'b0;
            if (respawn_done)
                respawn <= 1'b0;
            else if (move_tick && !respawn && hit)
            begin
                respawn <= 1'b1;
                // Hit with no lives left restarts the game
                if (lives == 2'd0)
                begin
                    lives <= LIVES_AFTER_OVER;
                    game_over <= 1'b1;
                end
                else
                    lives <= lives - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/score_keeper.sv */
// Running score and high score registers
`timescale 1ns/1ps
`default_nettype none

module score_keeper
    (
    input logic CLOCK_50,
    input logic reset,
    input logic score_tick,
    input logic game_over,
    output logic [7:0] score,
    output logic [7:0] high_score
    );

    always_ff @(posedge CLOCK_50)
    begin
        if (reset)
        begin
            score <= 8'd0;
            high_score <= 8'd0;
        end
        else
        begin
            if (game_over)
                score <= 8'd0;
            else if (score_tick)
                score <= score + 8'd1;
            // Survives game over
            if (score > high_score)
                high_score <= score;
        end
    end

endmodule

`default_nettype wire

/* rtl/plot_arbiter.sv */
// Fixed priority arbiter merging the sprite pixel requests onto one pixel port
`timescale 1ns/1ps
`default_nettype none

module plot_arbiter
    (
    plot_if.sink player_plot,
    plot_if.sink bee_plot [bounce_pkg::NUM_BEES],
    input logic CLOCK_50,
    input logic reset,
    input logic pixel_ready,
    output logic pixel_valid,
    output bounce_pkg::x_t pixel_x,
    output bounce_pkg::y_t pixel_y,
    output bounce_pkg::colour_t pixel_colour
    );

    import bounce_pkg::*;

    logic [NUM_SRCS-1:0] req;
    x_t [NUM_SRCS-1:0] src_x;
    y_t [NUM_SRCS-1:0] src_y;
    colour_t [NUM_SRCS-1:0] src_colour;
    logic [SRC_W-1:0] pick;
    logic [SRC_W-1:0] grant;
    logic [SRC_W-1:0] grant_q;
    logic locked;

    // Source 0 is the player
    assign req[0] = player_plot.valid;
    assign src_x[0] = player_plot.x;
    assign src_y[0] = player_plot.y;
    assign src_colour[0] = player_plot.colour;
    assign player_plot.ready = pixel_ready && pixel_valid && (grant == '0);

    for (genvar i = 0; i < NUM_BEES; i++)
    begin : g_bee
        assign req[i + 1] = bee_plot[i].valid;
        assign src_x[i + 1] = bee_plot[i].x;
        assign src_y[i + 1] = bee_plot[i].y;
        assign src_colour[i + 1] = bee_plot[i].colour;
        assign bee_plot[i].ready = pixel_ready && pixel_valid && (grant == SRC_W'(i + 1));
    end

    // Lowest index wins
    always_comb
    begin
        pick = '0;
        for (int i = NUM_SRCS - 1; i >= 0; i--)
        begin
            if (req[i])
                pick = SRC_W'(i);
        end
    end

    // A stalled request keeps its grant until it transfers
    assign grant = locked ? grant_q : pick;

    assign pixel_valid = |req;
    assign pixel_x = src_x[grant];
    assign pixel_y = src_y[grant];
    assign pixel_colour = src_colour[grant];

    always_ff @(posedge CLOCK_50)
    begin
        if (reset)
        begin
            locked <= 1'b0;
            grant_q <= '0;
        end
        else
        begin
            locked <= pixel_valid && !pixel_ready;
            grant_q <= grant;
        end
    end

endmodule

`default_nettype wire

/* rtl/bounce_top.sv */
// Top level of the bee dodging game logic
`timescale 1ns/1ps
`default_nettype none

module bounce_top
    (
    input logic CLOCK_50,
    input logic reset,
    input logic [3:0] keys,
    input logic fast,
    input logic [bounce_pkg::NUM_BEES-1:0] bee_enable,
    input logic pixel_ready,
    output logic pixel_valid,
    output bounce_pkg::x_t pixel_x,
    output bounce_pkg::y_t pixel_y,
    output bounce_pkg::colour_t pixel_colour,
    output logic [1:0] lives,
    output logic [7:0] score,
    output logic [7:0] high_score,
    output logic game_over
    );

    import bounce_pkg::*;

    logic move_tick;
    logic score_tick;
    logic respawn;
    logic respawn_done;
    x_t player_x;
    y_t player_y;
    x_t bee_x [NUM_BEES];
    y_t bee_y [NUM_BEES];

    plot_if player_plot ();
    plot_if bee_plot [NUM_BEES] ();

    game_timer i_timer (
        .CLOCK_50(CLOCK_50), .reset(reset), .fast(fast),
        .move_tick(move_tick), .score_tick(score_tick)
    );

    player_mover i_player (
        .CLOCK_50(CLOCK_50), .reset(reset), .move_tick(move_tick), .keys(keys),
        .lives(lives), .respawn(respawn), .respawn_done(respawn_done),
        .player_x(player_x), .player_y(player_y), .plot(player_plot)
    );

    // Bee start spots and headings
    bee_mover #(.START_X(8'd30), .START_Y(7'd48),
                .START_HEADING('{x_left: 1'b0, y_up: 1'b0})) i_bee0 (
        .CLOCK_50(CLOCK_50), .reset(reset), .move_tick(move_tick), .enable(bee_enable[0]),
        .bee_x(bee_x[0]), .bee_y(bee_y[0]), .plot(bee_plot[0])
    );

    bee_mover #(.START_X(8'd34), .START_Y(7'd74),
                .START_HEADING('{x_left: 1'b1, y_up: 1'b0})) i_bee1 (
        .CLOCK_50(CLOCK_50), .reset(reset), .move_tick(move_tick), .enable(bee_enable[1]),
        .bee_x(bee_x[1]), .bee_y(bee_y[1]), .plot(bee_plot[1])
    );

    bee_mover #(.START_X(8'd103), .START_Y(7'd89),
                .START_HEADING('{x_left: 1'b0, y_up: 1'b1})) i_bee2 (
        .CLOCK_50(CLOCK_50), .reset(reset), .move_tick(move_tick), .enable(bee_enable[2]),
        .bee_x(bee_x[2]), .bee_y(bee_y[2]), .plot(bee_plot[2])
    );

    bee_mover #(.START_X(8'd67), .START_Y(7'd100),
                .START_HEADING('{x_left: 1'b1, y_up: 1'b1})) i_bee3 (
        .CLOCK_50(CLOCK_50), .reset(reset), .move_tick(move_tick), .enable(bee_enable[3]),
        .bee_x(bee_x[3]), .bee_y(bee_y[3]), .plot(bee_plot[3])
    );

    collision_lives i_collision (
        .CLOCK_50(CLOCK_50), .reset(reset), .move_tick(move_tick),
        .player_x(player_x), .player_y(player_y), .bee_x(bee_x), .bee_y(bee_y),
        .bee_enable(bee_enable), .respawn_done(respawn_done),
        .lives(lives), .respawn(respawn), .game_over(game_over)
    );

    score_keeper i_score (
        .CLOCK_50(CLOCK_50), .reset(reset), .score_tick(score_tick), .game_over(game_over),
        .score(score), .high_score(high_score)
    );

    plot_arbiter i_arbiter (
        .player_plot(player_plot), .bee_plot(bee_plot),
        .CLOCK_50(CLOCK_50), .reset(reset), .pixel_ready(pixel_ready),
        .pixel_valid(pixel_valid), .pixel_x(pixel_x), .pixel_y(pixel_y),
        .pixel_colour(pixel_colour)
    );

endmodule

`default_nettype wire

/* testbench/bounce_checker.sv */
// Concurrent assertions on the pixel port, lives, score and high score of the game top level
`timescale 1ns/1ps
`default_nettype none

module bounce_checker
    (
    input logic CLOCK_50,
    input logic reset,
    input logic pixel_valid,
    input logic pixel_ready,
    input bounce_pkg::x_t pixel_x,
    input bounce_pkg::y_t pixel_y,
    input bounce_pkg::colour_t pixel_colour,
    input logic [1:0] lives,
    input logic [7:0] score,
    input logic [7:0] high_score,
    input logic game_over
    );

    import bounce_pkg::*;

    int unsigned error_count = 0;

    logic reset_q;
    x_t x_q;
    y_t y_q;
    colour_t colour_q;
    logic [1:0] lives_q;
    logic [7:0] score_q;
    logic [7:0] high_q;
    logic over_q;
    logic tick_q;
    logic [TICK_CNT_W-1:0] score_wait;
    logic [7:0] score_expect;

    // Clocks left until the score timer fires, counted from reset release
    always_ff @(posedge CLOCK_50)
    begin
        if (reset || score_wait == '0)
            score_wait <= TICK_CNT_W'(SCORE_CYCLES - 1);
        else
            score_wait <= score_wait - TICK_CNT_W'(1);
    end

    // Values of the previous cycle
    always_ff @(posedge CLOCK_50)
    begin
        reset_q <= reset;
        x_q <= pixel_x;
        y_q <= pixel_y;
        colour_q <= pixel_colour;
        lives_q <= lives;
        score_q <= score;
        high_q <= high_score;
        over_q <= game_over;
        tick_q <= (score_wait == '0);
    end

    // Clear beats the timer step
    always_comb
    begin
        if (over_q)
            score_expect = 8'd0;
        else if (tick_q)
            score_expect = score_q + 8'd1;
        else
            score_expect = score_q;
    end

    a_reset_values: assert property (@(posedge CLOCK_50)
        reset_q && !reset |-> lives == LIVES_START && score == 8'd0 && high_score == 8'd0
                              && !pixel_valid && !game_over)
    else
    begin
        error_count = error_count + 1;
        $error("error at %0t: %s expected %0d/0/0/0/0 actual %0d/%0d/%0d/%0b/%0b",
               $time, "lives/score/high_score/pixel_valid/game_over after reset",
               LIVES_START, $sampled(lives), $sampled(score), $sampled(high_score),
               $sampled(pixel_valid), $sampled(game_over));
    end

    a_stall_hold: assert property (@(posedge CLOCK_50) disable iff (reset)
        pixel_valid && !pixel_ready |=> pixel_valid && pixel_x == x_q && pixel_y == y_q
                                        && pixel_colour == colour_q)
    else
    begin
        error_count = error_count + 1;
        $error("error at %0t: pixel_valid/x/y/colour expected 1/%0d/%0d/%0d actual %0b/%0d/%0d/%0d",
               $time, $sampled(x_q), $sampled(y_q), $sampled(colour_q), $sampled(pixel_valid),
               $sampled(pixel_x), $sampled(pixel_y), $sampled(pixel_colour));
    end

    a_in_field: assert property (@(posedge CLOCK_50) disable iff (reset)
        pixel_valid && pixel_ready |-> pixel_x < FIELD_W && pixel_y < FIELD_H)
    else
    begin
        error_count = error_count + 1;
        $error("error at %0t: pixel_x/pixel_y expected below %0d/%0d actual %0d/%0d",
               $time, FIELD_W, FIELD_H, $sampled(pixel_x), $sampled(pixel_y));
    end

    a_score_step: assert property (@(posedge CLOCK_50) disable iff (reset)
        score == score_expect)
    else
    begin
        error_count = error_count + 1;
        $error("error at %0t: score expected %0d actual %0d",
               $time, $sampled(score_expect), $sampled(score));
    end

    a_lives_step: assert property (@(posedge CLOCK_50) disable iff (reset)
        lives != lives_q |-> (lives_q != 2'd0 && lives == lives_q - 2'd1 && !game_over)
                             || (lives_q == 2'd0 && lives == LIVES_AFTER_OVER && game_over))
    else
    begin
        error_count = error_count + 1;
        $error("error at %0t: lives expected %0d actual %0d (game_over %0b)", $time,
               ($sampled(lives_q) == 2'd0) ? LIVES_AFTER_OVER : $sampled(lives_q) - 2'd1,
               $sampled(lives), $sampled(game_over));
    end

    a_game_over: assert property (@(posedge CLOCK_50) disable iff (reset)
        game_over |-> lives_q == 2'd0 && lives == LIVES_AFTER_OVER)
    else
    begin
        error_count = error_count + 1;
        $error("error at %0t: lives on game_over expected 0 -> %0d actual %0d -> %0d",
               $time, LIVES_AFTER_OVER, $sampled(lives_q), $sampled(lives));
    end

    a_high_kept: assert property (@(posedge CLOCK_50) disable iff (reset)
        high_score >= high_q)
    else
    begin
        error_count = error_count + 1;
        $error("error at %0t: high_score expected at least %0d actual %0d",
               $time, $sampled(high_q), $sampled(high_score));
    end

    // High score trails the score by one cycle
    a_high_covers: assert property (@(posedge CLOCK_50) disable iff (reset)
        high_score >= score_q)
    else
    begin
        error_count = error_count + 1;
        $error("error at %0t: high_score expected at least score %0d actual %0d",
               $time, $sampled(score_q), $sampled(high_score));
    end

endmodule

bind bounce_top bounce_checker i_checker (.*);

`default_nettype wire

/* testbench/bounce_tb.sv */
// Testbench for the bee dodging game, driving stall, wall and random play phases
`timescale 1ns/1ps
`default_nettype none

module bounce_tb;

    import bounce_pkg::*;

    localparam int CLOCK_PERIOD = 100;
    localparam int RESET_CYCLES = 2;
    localparam int STALL_CYCLES = 40;
    localparam int PHASE1_CYCLES = 300;
    // Walk from the start column to the wall per life, with room for skipped ticks
    localparam int PHASE2_CYCLES = 6 * (PLAYER_START_X - X_MIN + 1) * SLOW_MOVE_CYCLES * 2;
    localparam int PHASE3_CYCLES = 3000;
    localparam int MARGIN_CYCLES = 500;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + STALL_CYCLES + PHASE1_CYCLES
                                   + PHASE2_CYCLES + PHASE3_CYCLES + MARGIN_CYCLES;
    localparam logic [31:0] LFSR_SEED = 32'hdbbbf533;
    localparam logic [3:0] KEY_LEFT = 4'b0010;

    logic CLOCK_50 = 1'b0;
    logic reset;
    logic [3:0] keys;
    logic fast;
    logic [NUM_BEES-1:0] bee_enable;
    logic pixel_ready;
    logic pixel_valid;
    x_t pixel_x;
    y_t pixel_y;
    colour_t pixel_colour;
    logic [1:0] lives;
    logic [7:0] score;
    logic [7:0] high_score;
    logic game_over;

    logic [31:0] lfsr_state;
    logic [1:0] lives_seen;
    int lives_lost;
    logic game_over_seen;

    always #(CLOCK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;

    bounce_top i_dut (
        .CLOCK_50(CLOCK_50), .reset(reset), .keys(keys), .fast(fast),
        .bee_enable(bee_enable), .pixel_ready(pixel_ready), .pixel_valid(pixel_valid),
        .pixel_x(pixel_x), .pixel_y(pixel_y), .pixel_colour(pixel_colour),
        .lives(lives), .score(score), .high_score(high_score), .game_over(game_over)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic random_bit(output logic b);
        b = lfsr_state[31];
        lfsr_state = lfsr_step(lfsr_state);
    endtask

    // Ready high about three cycles in four
    task automatic drive_ready_random();
        logic b0;
        logic b1;
        random_bit(b0);
        random_bit(b1);
        pixel_ready <= b0 | b1;
    endtask

    task automatic drive_keys_random();
        logic [3:0] k;
        logic b;
        for (int i = 0; i < 4; i++)
        begin
            random_bit(b);
            k[i] = b;
        end
        keys <= k;
    endtask

    task automatic stop_with_failure(input string reason);
        $display("TEST FAIL");
        $fatal(1, "%s", reason);
    endtask

    // Every change of lives is one life lost
    always @(negedge CLOCK_50)
    begin
        if (!reset)
        begin
            if (game_over)
                game_over_seen = 1'b1;
            if (lives != lives_seen)
                lives_lost = lives_lost + 1;
            lives_seen = lives;
        end
    end

    always @(negedge CLOCK_50)
    begin
        if (i_dut.i_checker.error_count != 0)
            stop_with_failure("an assertion in the checker failed");
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        stop_with_failure("watchdog expired before the test finished");
    end

    initial
    begin
        reset = 1'b1;
        keys = 4'b0000;
        fast = 1'b0;
        bee_enable = '0;
        pixel_ready = 1'b0;
        lfsr_state = LFSR_SEED;
        lives_seen = LIVES_START;
        lives_lost = 0;
        game_over_seen = 1'b0;

        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        reset <= 1'b0;

        // Bees off and no keys, pixel port held off first
        repeat (STALL_CYCLES) @(posedge CLOCK_50);
        for (int i = 0; i < PHASE1_CYCLES; i++)
        begin
            @(posedge CLOCK_50);
            drive_ready_random();
        end

        // Run into the left wall until game over has passed
        keys <= KEY_LEFT;
        while (lives_lost <= 4)
        begin
            @(posedge CLOCK_50);
            drive_ready_random();
        end

        bee_enable <= '1;
        fast <= 1'b1;
        for (int i = 0; i < PHASE3_CYCLES; i++)
        begin
            @(posedge CLOCK_50);
            drive_ready_random();
            drive_keys_random();
        end
        // Assertions of the last edge have settled by the falling edge
        @(negedge CLOCK_50);

        if (i_dut.i_checker.error_count != 0)
            stop_with_failure("the checker recorded assertion failures");
        else if (!game_over_seen)
            stop_with_failure("holding left with the bees off never reached game over");
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
rtl/bounce_pkg.sv
rtl/plot_if.sv
rtl/game_timer.sv
rtl/player_mover.sv
rtl/bee_mover.sv
rtl/collision_lives.sv
rtl/score_keeper.sv
rtl/plot_arbiter.sv
rtl/bounce_top.sv
testbench/bounce_checker.sv
testbench/bounce_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the bee game testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

log=sim.log
build=obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module bounce_tb \
    -f vlog.f --Mdir "$build" -o bounce_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build/bounce_sim" +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TEST FAIL" "$log"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
